//--- udp_rx_defines.svh
// Widths, protocol constants and FIFO depth for the UDP receive path
`ifndef UDP_RX_DEFINES_SVH
`define UDP_RX_DEFINES_SVH

// Avalon-ST beat geometry
`define UDP_RX_BEAT_WIDTH     256
`define UDP_RX_EMPTY_WIDTH    5
`define UDP_RX_BEAT_BYTES     32

// Payload capacity and the share carried by the header-data beat
`define UDP_RX_PAYLOAD_BYTES  64
`define UDP_RX_FIRST_BYTES    22

// Protocol constants
`define UDP_RX_UDP_HDR_BYTES  8
`define UDP_RX_PROTO_UDP      8'd17
`define UDP_RX_IP_VERSION     4'd4
`define UDP_RX_BROADCAST_MAC  48'hFFFF_FFFF_FFFF

// Buffering and statistics
`define UDP_RX_FIFO_DEPTH     4
`define UDP_RX_STAT_WIDTH     16

`endif

//--- udp_rx_pkg.sv
// Header, frame, packet and statistics types for the UDP receive path
`include "udp_rx_defines.svh"

package udp_rx_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ipv4_addr_t;

    // 14 bytes
    typedef struct packed {
        mac_addr_t   dest_mac;
        mac_addr_t   src_mac;
        logic [15:0] length;
    } eth_hdr_t;

    // 20 bytes, no options
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  time_to_live;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        ipv4_addr_t  src_ip;
        ipv4_addr_t  dest_ip;
    } ip_hdr_t;

    // 8 bytes, length covers header and payload
    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // Everything the parser collects from one frame
    typedef struct packed {
        eth_hdr_t                             eth;
        ip_hdr_t                              ip;
        udp_hdr_t                             udp;
        logic [`UDP_RX_PAYLOAD_BYTES*8-1:0]   payload;
        logic [15:0]                          byte_count;
    } rx_frame_t;

    // What the application sees
    typedef struct packed {
        ipv4_addr_t                           src_ip;
        ipv4_addr_t                           dest_ip;
        logic [15:0]                          src_port;
        logic [15:0]                          dest_port;
        logic [15:0]                          length;
        logic [`UDP_RX_PAYLOAD_BYTES*8-1:0]   payload;
    } rx_packet_t;

    typedef struct packed {
        logic [`UDP_RX_STAT_WIDTH-1:0] dest_mac_err;
        logic [`UDP_RX_STAT_WIDTH-1:0] dest_ip_err;
        logic [`UDP_RX_STAT_WIDTH-1:0] protocol_err;
        logic [`UDP_RX_STAT_WIDTH-1:0] version_err;
        logic [`UDP_RX_STAT_WIDTH-1:0] length_err;
        logic [`UDP_RX_STAT_WIDTH-1:0] filter_drop;
        logic [`UDP_RX_STAT_WIDTH-1:0] fifo_drop;
    } rx_stats_t;

endpackage

//--- rx_frame_parser.sv
// Avalon-ST beat parser that assembles headers, payload and byte count per frame
`timescale 1ns/1ns
`include "udp_rx_defines.svh"

module rx_frame_parser (
    input  logic                              rx_clk_in,
    input  logic                              rx_reset_in,
    input  logic [`UDP_RX_BEAT_WIDTH-1:0]     rx_data_in,
    input  logic                              rx_valid_in,
    input  logic                              rx_sop_in,
    input  logic                              rx_eop_in,
    input  logic [`UDP_RX_EMPTY_WIDTH-1:0]    rx_empty_in,
    output udp_rx_pkg::rx_frame_t             frame,
    output logic                              frame_valid
);

    localparam int PAYLOAD_BITS = `UDP_RX_PAYLOAD_BYTES * 8;

    typedef enum logic [1:0] {
        ST_HEADER,
        ST_HDR_DATA,
        ST_DATA
    } parse_state_t;

    parse_state_t state, state_next;

    // Frame under construction
    udp_rx_pkg::rx_frame_t work, work_next;

    logic                    frame_done;
    logic [PAYLOAD_BITS-1:0] beat_wide;
    logic [8:0]              shift_bits;
    logic [15:0]             beat_bytes;

    // ==============================
    // Beat placement
    // ==============================
    assign beat_wide  = {{(PAYLOAD_BITS - `UDP_RX_BEAT_WIDTH){1'b0}}, rx_data_in};
    assign shift_bits = {work.byte_count[5:0], 3'b000};

    // Only the last beat may be partial
    assign beat_bytes = rx_eop_in ? (16'(`UDP_RX_BEAT_BYTES) - 16'(rx_empty_in))
                                  : 16'(`UDP_RX_BEAT_BYTES);

    always_comb begin
        state_next = state;
        work_next  = work;
        frame_done = 1'b0;

        case (state)
            ST_HEADER: begin
                // Ethernet header plus the first 18 IP bytes
                if (rx_valid_in && rx_sop_in) begin
                    work_next.eth         = rx_data_in[255:144];
                    work_next.ip[159:16]  = rx_data_in[143:0];
                    work_next.payload     = '0;
                    work_next.byte_count  = '0;
                    state_next            = ST_HDR_DATA;
                end
            end

            ST_HDR_DATA: begin
                if (rx_valid_in) begin
                    work_next.ip[15:0]    = rx_data_in[255:240];
                    work_next.udp         = rx_data_in[239:176];
                    work_next.payload[`UDP_RX_FIRST_BYTES*8-1:0] =
                        rx_data_in[`UDP_RX_FIRST_BYTES*8-1:0];
                    // Empty is ignored on a short frame
                    work_next.byte_count  = 16'(`UDP_RX_FIRST_BYTES);
                    if (rx_eop_in) begin
                        frame_done = 1'b1;
                        state_next = ST_HEADER;
                    end else begin
                        state_next = ST_DATA;
                    end
                end
            end

            ST_DATA: begin
                if (rx_valid_in) begin
                    // Bytes past the payload capacity are counted only
                    if (work.byte_count < 16'(`UDP_RX_PAYLOAD_BYTES))
                        work_next.payload = work.payload | (beat_wide << shift_bits);
                    work_next.byte_count = work.byte_count + beat_bytes;
                    if (rx_eop_in) begin
                        frame_done = 1'b1;
                        state_next = ST_HEADER;
                    end
                end
            end

            default: state_next = ST_HEADER;
        endcase
    end

    // ==============================
    // Registers
    // ==============================
    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            state       <= ST_HEADER;
            frame_valid <= 1'b0;
        end else begin
            state       <= state_next;
            frame_valid <= frame_done;
        end
    end

    always_ff @(posedge rx_clk_in) begin
        work <= work_next;
        if (frame_done)
            frame <= work_next;
    end

endmodule

//--- rx_header_check.sv
// Address and protocol filter with drop decision and error counters
`timescale 1ns/1ns
`include "udp_rx_defines.svh"

module rx_header_check (
    input  logic                       rx_clk_in,
    input  logic                       rx_reset_in,
    input  udp_rx_pkg::rx_frame_t      frame,
    input  logic                       frame_valid,
    input  udp_rx_pkg::mac_addr_t      host_mac,
    input  udp_rx_pkg::ipv4_addr_t     host_ip,
    output udp_rx_pkg::rx_packet_t     push_pkt,
    output logic                       push_valid,
    output udp_rx_pkg::rx_stats_t      filter_stats
);

    logic mac_err, ip_err, proto_err, version_err, length_err;
    logic drop;
    logic [15:0] pkt_length;

    // Counters live here, fifo_drop is never touched and stays zero
    udp_rx_pkg::rx_stats_t counters;

    assign mac_err     = (frame.eth.dest_mac != host_mac) &&
                         (frame.eth.dest_mac != `UDP_RX_BROADCAST_MAC);
    assign ip_err      = frame.ip.dest_ip != host_ip;
    assign proto_err   = frame.ip.protocol != `UDP_RX_PROTO_UDP;
    assign version_err = frame.ip.version != `UDP_RX_IP_VERSION;
    // Length mismatch is reported but the frame still goes through
    assign length_err  = (frame.udp.length - 16'(`UDP_RX_UDP_HDR_BYTES)) != frame.byte_count;
    assign drop        = mac_err | ip_err | proto_err | version_err;

    assign pkt_length  = (frame.byte_count > 16'(`UDP_RX_PAYLOAD_BYTES)) ?
                         16'(`UDP_RX_PAYLOAD_BYTES) : frame.byte_count;

    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            push_valid <= 1'b0;
            counters   <= '0;
        end else begin
            push_valid <= frame_valid && !drop;
            if (frame_valid) begin
                if (mac_err)
                    counters.dest_mac_err <= counters.dest_mac_err + 1'b1;
                if (ip_err)
                    counters.dest_ip_err <= counters.dest_ip_err + 1'b1;
                if (proto_err)
                    counters.protocol_err <= counters.protocol_err + 1'b1;
                if (version_err)
                    counters.version_err <= counters.version_err + 1'b1;
                if (length_err)
                    counters.length_err <= counters.length_err + 1'b1;
                // One per dropped frame, however many causes hit
                if (drop)
                    counters.filter_drop <= counters.filter_drop + 1'b1;
            end
        end
    end

    // Application packet, only meaningful with push_valid
    always_ff @(posedge rx_clk_in) begin
        if (frame_valid) begin
            push_pkt.src_ip    <= frame.ip.src_ip;
            push_pkt.dest_ip   <= frame.ip.dest_ip;
            push_pkt.src_port  <= frame.udp.src_port;
            push_pkt.dest_port <= frame.udp.dest_port;
            push_pkt.length    <= pkt_length;
            push_pkt.payload   <= frame.payload;
        end
    end

    assign filter_stats = counters;

endmodule

//--- rx_packet_fifo.sv
// Synchronous packet FIFO that discards and counts pushes when full
`timescale 1ns/1ns
`include "udp_rx_defines.svh"

module rx_packet_fifo (
    input  logic                            rx_clk_in,
    input  logic                            rx_reset_in,
    input  udp_rx_pkg::rx_packet_t          push_pkt,
    input  logic                            push_valid,
    input  logic                            pop,
    output udp_rx_pkg::rx_packet_t          pop_pkt,
    output logic                            not_empty,
    output logic [`UDP_RX_STAT_WIDTH-1:0]   fifo_drop
);

    localparam int DEPTH = `UDP_RX_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    udp_rx_pkg::rx_packet_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push, do_pop;

    assign full      = count == CNT_W'(DEPTH);
    assign not_empty = count != '0;
    // Full is judged before a same-cycle pop frees a slot
    assign do_push   = push_valid && !full;
    assign do_pop    = pop && not_empty;

    // Show-ahead read
    assign pop_pkt = mem[rd_ptr];

    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            fifo_drop <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
            // Whole packet lost on overflow
            if (push_valid && full)
                fifo_drop <= fifo_drop + 1'b1;
        end
    end

    always_ff @(posedge rx_clk_in) begin
        if (do_push)
            mem[wr_ptr] <= push_pkt;
    end

endmodule

//--- rx_delivery.sv
// Packet delivery FSM with a four-phase req/ack handshake to the application
`timescale 1ns/1ns

module rx_delivery (
    input  logic                      rx_clk_in,
    input  logic                      rx_reset_in,
    input  udp_rx_pkg::rx_packet_t    pop_pkt,
    input  logic                      not_empty,
    input  logic                      pkt_ack,
    output logic                      pop,
    output udp_rx_pkg::rx_packet_t    pkt_out,
    output logic                      pkt_req
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_RELEASE,
        ST_WAIT_ACK_LOW
    } dlv_state_t;

    dlv_state_t state;

    // Ack is always low in idle, so a new request never overlaps the old ack
    assign pop     = (state == ST_IDLE) && not_empty;
    assign pkt_req = state == ST_REQ;

    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:         if (not_empty) state <= ST_REQ;
                ST_REQ:          if (pkt_ack) state <= ST_RELEASE;
                // Req drops here
                ST_RELEASE:      state <= ST_WAIT_ACK_LOW;
                ST_WAIT_ACK_LOW: if (!pkt_ack) state <= ST_IDLE;
                default:         state <= ST_IDLE;
            endcase
        end
    end

    // Holding register, stable until the next pop
    always_ff @(posedge rx_clk_in) begin
        if (pop)
            pkt_out <= pop_pkt;
    end

endmodule

//--- udp_rx_top.sv
// UDP receive top level joining parser, filter, packet FIFO and delivery
`timescale 1ns/1ns
`include "udp_rx_defines.svh"

module udp_rx_top (
    input  logic                              rx_clk_in,
    input  logic                              rx_reset_in,
    input  logic [`UDP_RX_BEAT_WIDTH-1:0]     rx_data_in,
    input  logic                              rx_valid_in,
    input  logic                              rx_sop_in,
    input  logic                              rx_eop_in,
    input  logic [`UDP_RX_EMPTY_WIDTH-1:0]    rx_empty_in,
    input  udp_rx_pkg::mac_addr_t             host_mac,
    input  udp_rx_pkg::ipv4_addr_t            host_ip,
    input  logic                              pkt_ack,
    output logic                              rx_ready_out,
    output udp_rx_pkg::rx_packet_t            pkt_out,
    output logic                              pkt_req,
    output udp_rx_pkg::rx_stats_t             stats
);

    udp_rx_pkg::rx_frame_t   frame;
    logic                    frame_valid;
    udp_rx_pkg::rx_packet_t  push_pkt;
    logic                    push_valid;
    udp_rx_pkg::rx_stats_t   filter_stats;
    udp_rx_pkg::rx_packet_t  pop_pkt;
    logic                    not_empty;
    logic                    pop;
    logic [`UDP_RX_STAT_WIDTH-1:0] fifo_drop;

    rx_frame_parser u_parser (
        .rx_clk_in   (rx_clk_in),
        .rx_reset_in (rx_reset_in),
        .rx_data_in  (rx_data_in),
        .rx_valid_in (rx_valid_in),
        .rx_sop_in   (rx_sop_in),
        .rx_eop_in   (rx_eop_in),
        .rx_empty_in (rx_empty_in),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    rx_header_check u_check (
        .rx_clk_in    (rx_clk_in),
        .rx_reset_in  (rx_reset_in),
        .frame        (frame),
        .frame_valid  (frame_valid),
        .host_mac     (host_mac),
        .host_ip      (host_ip),
        .push_pkt     (push_pkt),
        .push_valid   (push_valid),
        .filter_stats (filter_stats)
    );

    rx_packet_fifo u_fifo (
        .rx_clk_in   (rx_clk_in),
        .rx_reset_in (rx_reset_in),
        .push_pkt    (push_pkt),
        .push_valid  (push_valid),
        .pop         (pop),
        .pop_pkt     (pop_pkt),
        .not_empty   (not_empty),
        .fifo_drop   (fifo_drop)
    );

    rx_delivery u_delivery (
        .rx_clk_in   (rx_clk_in),
        .rx_reset_in (rx_reset_in),
        .pop_pkt     (pop_pkt),
        .not_empty   (not_empty),
        .pkt_ack     (pkt_ack),
        .pop         (pop),
        .pkt_out     (pkt_out),
        .pkt_req     (pkt_req)
    );

    // ==============================
    // Stats and ready
    // ==============================
    always_comb begin
        stats           = filter_stats;
        stats.fifo_drop = fifo_drop;
    end

    // No back-pressure, overflow is handled by the FIFO drop
    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in)
            rx_ready_out <= 1'b0;
        else
            rx_ready_out <= 1'b1;
    end

endmodule

//--- tb_udp_rx.sv
// Testbench for the UDP receive path driven by packets from the data file
`timescale 1ns/1ns

module tb_udp_rx;

    localparam int MAX_LINES      = 32;
    localparam int READY_TIMEOUT  = 20;
    localparam int REQ_TIMEOUT    = 50;
    localparam int DRAIN_TIMEOUT  = 2000;

    // Packet kinds in the data file
    localparam int KIND_BCAST     = 2;
    localparam int KIND_BAD_MAC   = 3;
    localparam int KIND_BAD_IP    = 4;
    localparam int KIND_BAD_PROTO = 5;
    localparam int KIND_BAD_VER   = 6;
    localparam int KIND_LEN_ERR   = 7;

    logic                    rx_clk_in;
    logic                    rx_reset_in;
    logic [255:0]            rx_data_in;
    logic                    rx_valid_in;
    logic                    rx_sop_in;
    logic                    rx_eop_in;
    logic [4:0]              rx_empty_in;
    udp_rx_pkg::mac_addr_t   host_mac;
    udp_rx_pkg::ipv4_addr_t  host_ip;
    logic                    pkt_ack;
    logic                    rx_ready_out;
    udp_rx_pkg::rx_packet_t  pkt_out;
    logic                    pkt_req;
    udp_rx_pkg::rx_stats_t   stats;

    udp_rx_pkg::rx_packet_t  exp_pkt_q[$];
    int                      exp_delay_q[$];
    udp_rx_pkg::rx_stats_t   exp_stats;
    udp_rx_pkg::rx_packet_t  held_pkt;
    logic [27:0]             vectors [0:MAX_LINES-1];
    integer                  seed;
    int                      value_errors;
    int                      other_errors;
    int                      ack_delay;
    int                      ack_cycles;
    int                      line_idx;
    int                      wait_cycles;
    logic                    req_prev;

    udp_rx_top UUT (
        .rx_clk_in    (rx_clk_in),
        .rx_reset_in  (rx_reset_in),
        .rx_data_in   (rx_data_in),
        .rx_valid_in  (rx_valid_in),
        .rx_sop_in    (rx_sop_in),
        .rx_eop_in    (rx_eop_in),
        .rx_empty_in  (rx_empty_in),
        .host_mac     (host_mac),
        .host_ip      (host_ip),
        .pkt_ack      (pkt_ack),
        .rx_ready_out (rx_ready_out),
        .pkt_out      (pkt_out),
        .pkt_req      (pkt_req),
        .stats        (stats)
    );

    initial begin
        rx_clk_in = 1'b0;
        forever #4 rx_clk_in = ~rx_clk_in;
    end

    // ==============================
    // Helpers
    // ==============================
    task automatic check_value(input string name, input logic [639:0] got,
                               input logic [639:0] expected);
        if (got !== expected) begin
            value_errors++;
            $display("error: time %0t signal %s got %0h expected %0h",
                     $time, name, got, expected);
        end
    endtask

    task automatic send_beat(input logic [255:0] data, input logic sop, input logic eop,
                             input logic [4:0] empty);
        @(posedge rx_clk_in);
        rx_data_in  <= data;
        rx_valid_in <= 1'b1;
        rx_sop_in   <= sop;
        rx_eop_in   <= eop;
        rx_empty_in <= empty;
    endtask

    task automatic send_idle();
        @(posedge rx_clk_in);
        rx_data_in  <= '0;
        rx_valid_in <= 1'b0;
        rx_sop_in   <= 1'b0;
        rx_eop_in   <= 1'b0;
        rx_empty_in <= '0;
    endtask

    // Builds headers for one kind, queues the expected packet and drives the beats
    task automatic send_packet(input int index, input int kind, input int len,
                               input int delay, input logic expect_dlv);
        udp_rx_pkg::eth_hdr_t   eth;
        udp_rx_pkg::ip_hdr_t    ip;
        udp_rx_pkg::udp_hdr_t   udp;
        udp_rx_pkg::rx_packet_t pkt;
        logic [511:0]           payload;
        logic [255:0]           beat;
        int                     offset;
        int                     nbytes;
        int                     k;
        payload = '0;
        for (k = 0; k < len; k++)
            payload[8*k +: 8] = 8'($random(seed));
        eth.dest_mac = (kind == KIND_BCAST) ? 48'hFFFF_FFFF_FFFF : host_mac;
        if (kind == KIND_BAD_MAC)
            eth.dest_mac = host_mac ^ 48'h0000_0000_0101;
        eth.src_mac    = 48'h0200_0000_0001;
        eth.length     = 16'h0800;
        ip             = '0;
        ip.version     = (kind == KIND_BAD_VER) ? 4'd6 : 4'd4;
        ip.ihl         = 4'd5;
        ip.length      = 16'(28 + len);
        ip.time_to_live = 8'd64;
        ip.protocol    = (kind == KIND_BAD_PROTO) ? 8'd6 : 8'd17;
        ip.src_ip      = 32'h0A00_0001 + 32'(index);
        ip.dest_ip     = (kind == KIND_BAD_IP) ? host_ip + 32'd1 : host_ip;
        udp.src_port   = 16'h4000 + 16'(index);
        udp.dest_port  = 16'd5001;
        udp.length     = (kind == KIND_LEN_ERR) ? 16'(len + 13) : 16'(len + 8);
        udp.checksum   = '0;
        pkt.src_ip     = ip.src_ip;
        pkt.dest_ip    = ip.dest_ip;
        pkt.src_port   = udp.src_port;
        pkt.dest_port  = udp.dest_port;
        pkt.length     = 16'(len);
        pkt.payload    = payload;
        if (expect_dlv) begin
            exp_pkt_q.push_back(pkt);
            exp_delay_q.push_back(delay);
        end
        send_beat({eth, ip[159:16]}, 1'b1, 1'b0, 5'd0);
        send_beat({ip[15:0], udp, payload[175:0]}, 1'b0, len == 22, 5'd0);
        offset = 22;
        while (offset < len) begin
            nbytes = (len - offset > 32) ? 32 : len - offset;
            beat = '0;
            for (k = 0; k < nbytes; k++)
                beat[8*k +: 8] = payload[8*(offset+k) +: 8];
            send_beat(beat, 1'b0, offset + nbytes >= len, 5'(32 - nbytes));
            offset += nbytes;
        end
    endtask

    task automatic update_expected(input int kind, input logic expect_dlv);
        case (kind)
            KIND_BAD_MAC:   exp_stats.dest_mac_err = exp_stats.dest_mac_err + 1'b1;
            KIND_BAD_IP:    exp_stats.dest_ip_err  = exp_stats.dest_ip_err + 1'b1;
            KIND_BAD_PROTO: exp_stats.protocol_err = exp_stats.protocol_err + 1'b1;
            KIND_BAD_VER:   exp_stats.version_err  = exp_stats.version_err + 1'b1;
            KIND_LEN_ERR:   exp_stats.length_err   = exp_stats.length_err + 1'b1;
            default:        ;
        endcase
        if (kind >= KIND_BAD_MAC && kind <= KIND_BAD_VER)
            exp_stats.filter_drop = exp_stats.filter_drop + 1'b1;
        // Accepted by the filter but not delivered means lost in the FIFO
        else if (!expect_dlv)
            exp_stats.fifo_drop = exp_stats.fifo_drop + 1'b1;
    endtask

    task automatic wait_drain();
        wait_cycles = 0;
        while (exp_pkt_q.size() != 0 && wait_cycles < DRAIN_TIMEOUT) begin
            @(posedge rx_clk_in);
            wait_cycles++;
        end
        if (exp_pkt_q.size() != 0) begin
            other_errors++;
            $display("timeout: %0d expected packets never delivered by time %0t",
                     exp_pkt_q.size(), $time);
        end
    endtask

    // ==============================
    // Application side
    // ==============================
    initial begin
        pkt_ack = 1'b0;
        forever begin
            @(posedge rx_clk_in);
            if (pkt_req && !pkt_ack) begin
                held_pkt  = pkt_out;
                ack_delay = 0;
                if (exp_pkt_q.size() == 0) begin
                    other_errors++;
                    $display("unexpected packet delivered at time %0t", $time);
                end else begin
                    check_value("pkt_out.src_ip", held_pkt.src_ip, exp_pkt_q[0].src_ip);
                    check_value("pkt_out.dest_ip", held_pkt.dest_ip, exp_pkt_q[0].dest_ip);
                    check_value("pkt_out.src_port", held_pkt.src_port, exp_pkt_q[0].src_port);
                    check_value("pkt_out.dest_port", held_pkt.dest_port,
                                exp_pkt_q[0].dest_port);
                    check_value("pkt_out.length", held_pkt.length, exp_pkt_q[0].length);
                    check_value("pkt_out.payload", held_pkt.payload, exp_pkt_q[0].payload);
                    ack_delay = exp_delay_q[0];
                end
                // Packet must hold still while the request is pending
                for (ack_cycles = 0; ack_cycles < ack_delay; ack_cycles++) begin
                    @(posedge rx_clk_in);
                    check_value("pkt_out", pkt_out, held_pkt);
                end
                pkt_ack <= 1'b1;
                ack_cycles = 0;
                while (pkt_req && ack_cycles < REQ_TIMEOUT) begin
                    @(posedge rx_clk_in);
                    ack_cycles++;
                end
                if (pkt_req) begin
                    other_errors++;
                    $display("timeout: pkt_req stayed high after pkt_ack at time %0t", $time);
                end
                pkt_ack <= 1'b0;
                if (exp_pkt_q.size() != 0) begin
                    void'(exp_pkt_q.pop_front());
                    void'(exp_delay_q.pop_front());
                end
            end
        end
    end

    // A new request may only rise once ack is low
    always @(posedge rx_clk_in) begin
        if (pkt_req && !req_prev && pkt_ack) begin
            other_errors++;
            $display("pkt_req rose while pkt_ack was still high at time %0t", $time);
        end
        req_prev <= pkt_req;
    end

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        rx_reset_in  = 1'b1;
        rx_data_in   = '0;
        rx_valid_in  = 1'b0;
        rx_sop_in    = 1'b0;
        rx_eop_in    = 1'b0;
        rx_empty_in  = '0;
        host_mac     = 48'h02AA_BBCC_DD01;
        host_ip      = 32'hC0A8_0A02;
        req_prev     = 1'b0;
        seed         = 32'h397a_ff02;
        value_errors = 0;
        other_errors = 0;
        exp_stats    = '0;
        for (line_idx = 0; line_idx < MAX_LINES; line_idx++)
            vectors[line_idx] = '0;
        $readmemh("rx_input.txt", vectors);

        repeat (3) @(posedge rx_clk_in);
        check_value("rx_ready_out", rx_ready_out, 1'b0);
        rx_reset_in <= 1'b0;
        wait_cycles = 0;
        while (!rx_ready_out && wait_cycles < READY_TIMEOUT) begin
            @(posedge rx_clk_in);
            wait_cycles++;
        end
        if (!rx_ready_out) begin
            other_errors++;
            $display("timeout: rx_ready_out never rose after reset");
        end
        check_value("stats", stats, '0);
        check_value("pkt_req", pkt_req, 1'b0);

        line_idx = 0;
        while (line_idx < MAX_LINES && vectors[line_idx][27:24] != 4'd0) begin
            send_packet(line_idx, vectors[line_idx][27:24], vectors[line_idx][19:12],
                        vectors[line_idx][11:4], vectors[line_idx][0]);
            update_expected(vectors[line_idx][27:24], vectors[line_idx][0]);
            repeat (3) send_idle();
            // Burst packets go back to back and are settled at the end
            if (vectors[line_idx][23:20] == 4'd0) begin
                wait_drain();
                check_value("stats", stats, exp_stats);
            end
            line_idx++;
        end
        if (line_idx == 0) begin
            other_errors++;
            $display("no stimulus lines were read from rx_input.txt");
        end

        wait_drain();
        check_value("stats", stats, exp_stats);
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- rx_input.txt
// kind_burst_length_ackdelay_expect, hex fields, one packet per line
// kind 1 good, 2 broadcast, 3 bad MAC, 4 bad IP, 5 bad protocol, 6 bad version, 7 length error
1_0_16_01_1
2_0_1E_00_1
3_0_28_01_0
4_0_20_01_0
5_0_36_01_0
6_0_17_01_0
7_0_25_02_1
1_0_37_04_1
2_0_3F_02_1
1_0_40_00_1
3_0_16_01_0
// burst with a slow acknowledge, the last one overflows the FIFO
1_1_40_40_1
1_1_40_40_1
1_1_40_40_1
1_1_40_40_1
1_1_40_40_1
1_1_40_40_0

//--- files.f
+incdir+.
udp_rx_pkg.sv
rx_frame_parser.sv
rx_header_check.sv
rx_packet_fifo.sv
rx_delivery.sv
udp_rx_top.sv
tb_udp_rx.sv

//--- Bender.yml
package:
  name: udp_rx

sources:
  - include_dirs:
      - .
    files:
      - udp_rx_pkg.sv
      - rx_frame_parser.sv
      - rx_header_check.sv
      - rx_packet_fifo.sv
      - rx_delivery.sv
      - udp_rx_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_udp_rx.sv
